// ==== video_pkg.sv ====
// video package with mode, resolution and bandwidth codes plus raster window tables
package video_pkg;

	typedef logic [1:0] vmode_t;	// video mode from vconf[1:0]
	typedef logic [1:0] rres_t;	// raster resolution from vconf[7:6]
	typedef logic [1:0] rmode_t;	// render mode for the pixel renderer
	typedef logic [8:0] raster_t;	// raster coordinate
	typedef logic [20:0] vaddr_t;	// DRAM word address
	typedef logic [4:0] bw_t;	// {total[1:0], need[2:0]}

	// video modes
	localparam vmode_t M_ZX = 2'd0;	// ZX screen
	localparam vmode_t M_HC = 2'd1;	// 16 colours
	localparam vmode_t M_XC = 2'd2;	// 256 colours
	localparam vmode_t M_TX = 2'd3;	// text

	// raster resolutions
	localparam rres_t RES_256X192 = 2'd0;
	localparam rres_t RES_320X200 = 2'd1;
	localparam rres_t RES_320X240 = 2'd2;
	localparam rres_t RES_360X288 = 2'd3;

	// bandwidth total cycles, bits 4:3
	localparam logic [1:0] BW2 = 2'b00;
	localparam logic [1:0] BW4 = 2'b01;
	localparam logic [1:0] BW8 = 2'b11;

	// bandwidth needed cycles, one-hot bits 2:0
	localparam logic [2:0] BU1 = 3'b001;
	localparam logic [2:0] BU4 = 3'b100;

	// visible window per resolution, in raster coords
	localparam raster_t HP_BEG [4] = '{9'd140, 9'd108, 9'd108, 9'd88};
	localparam raster_t HP_END [4] = '{9'd396, 9'd428, 9'd428, 9'd448};
	localparam raster_t VP_BEG [4] = '{9'd80, 9'd76, 9'd56, 9'd32};
	localparam raster_t VP_END [4] = '{9'd272, 9'd276, 9'd296, 9'd320};

	// fetch lead before the window, per mode
	// covers DRAM latency plus renderer pipe
	localparam logic [4:0] G_OFFS [4] = '{5'd18, 5'd6, 5'd4, 5'd10};

	// pixel rate per mode, bit set = hires (text only)
	localparam logic [3:0] PIXRATE_HI = 4'b1000;

endpackage

// ==== video_timing.sv ====
// raster timing generator with pixel phase, line/frame counters and fetch window
`timescale 1ns/1ps

module video_timing #(
	parameter int H_TOTAL = 448,
	parameter int V_TOTAL = 320
) (
	input logic clk,
	input logic arst_n,
	input video_pkg::raster_t hpix_beg,
	input video_pkg::raster_t hpix_end,
	input video_pkg::raster_t vpix_beg,
	input video_pkg::raster_t vpix_end,
	input logic [4:0] go_offs,
	input logic fetch_stb,
	output logic c3,
	output logic f1,
	output logic line_start,
	output logic pix_start,
	output logic fetch_win,
	output logic [3:0] fetch_cnt,
	output logic [7:0] cnt_col,
	output video_pkg::raster_t cnt_row
);

	import video_pkg::*;

	logic [1:0] phase;	// clk/4 pixel phase
	raster_t hcount;
	raster_t vcount;
	raster_t hwin_beg;	// window start shifted by fetch lead
	raster_t hwin_end;
	logic h_wrap;
	logic v_wrap;
	logic v_valid;
	logic h_valid;

	assign c3 = phase == 2'd3;
	assign f1 = phase[0];	// odd phases

	assign h_wrap = hcount == raster_t'(H_TOTAL - 1);
	assign v_wrap = vcount == raster_t'(V_TOTAL - 1);
	assign line_start = c3 && h_wrap;

	// fetches run ahead of the visible area by go_offs
	assign hwin_beg = hpix_beg - raster_t'(go_offs);
	assign hwin_end = hpix_end - raster_t'(go_offs);

	assign v_valid = (vcount >= vpix_beg) && (vcount < vpix_end);
	assign h_valid = (hcount >= hwin_beg) && (hcount < hwin_end);
	assign fetch_win = v_valid && h_valid;
	assign pix_start = c3 && v_valid && (hcount == hwin_beg);

	assign cnt_row = vcount - vpix_beg;	// wraps outside the window, unused there

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phase <= '0;
			hcount <= '0;
			vcount <= '0;
		end
		else
		begin
			phase <= phase + 2'd1;
			if (c3)
			begin
				hcount <= h_wrap ? '0 : hcount + raster_t'(1);
				if (h_wrap)
					vcount <= v_wrap ? '0 : vcount + raster_t'(1);	// new frame
			end
		end
	end

	// fetch phase counter, restarts with the first fetch of a line
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			fetch_cnt <= '0;
		else if (pix_start)
			fetch_cnt <= '0;
		else if (c3 && fetch_win)
			fetch_cnt <= fetch_cnt + 4'd1;
	end

	// column counter, one step per issued fetch
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			cnt_col <= '0;
		else if (line_start)
			cnt_col <= '0;
		else if (fetch_stb)
			cnt_col <= cnt_col + 8'd1;
	end

	// fetch window shut before the line wraps
	a_win_closed: assert property (@(posedge clk) disable iff (!arst_n)
		line_start |-> !fetch_win);

endmodule

// ==== video_mode.sv ====
// video mode decoder with per-line config latch, fetch strobes, selects and DRAM address
`timescale 1ns/1ps

module video_mode (
	input logic clk,
	input logic arst_n,
	input logic c3,
	input logic f1,
	input logic line_start,
	input logic pix_start,
	input logic fetch_win,
	input logic [3:0] fetch_cnt,
	input logic [7:0] cnt_col,
	input video_pkg::raster_t cnt_row,
	input logic [7:0] vconf,
	input logic [7:0] vpage,
	input logic zvpage_wr,
	input logic [8:0] gx_offs,
	input logic [15:0] txt_char,
	output video_pkg::raster_t hpix_beg,
	output video_pkg::raster_t hpix_end,
	output video_pkg::raster_t vpix_beg,
	output video_pkg::raster_t vpix_end,
	output logic [4:0] go_offs,
	output logic [9:0] x_offs_mode,
	output video_pkg::rmode_t render_mode,
	output logic tv_hires,
	output logic vga_hires,
	output logic nogfx,
	output logic fetch_stb,
	output logic [3:0] fetch_sel,
	output logic [1:0] fetch_bsl,
	output video_pkg::vaddr_t video_addr,
	output video_pkg::bw_t video_bw
);

	import video_pkg::*;

	logic [7:0] vconf_d;	// config for current line
	logic [8:0] gx_offs_d;
	logic [7:0] vpage_d;
	logic zvpage_wr_r;	// page write lands one clock late
	vmode_t vmode;
	rres_t rres;
	logic ftch_rule;
	logic [11:0] addr_zx_gfx;
	logic [11:0] addr_zx_atr;
	logic [13:0] addr_tx;

	// config latch, hires to VGA is one line behind
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			vconf_d <= '0;
			gx_offs_d <= '0;
			vga_hires <= 1'b0;
		end
		else if (line_start)
		begin
			vconf_d <= vconf;
			gx_offs_d <= gx_offs;
			vga_hires <= tv_hires;	// old value
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			zvpage_wr_r <= 1'b0;
			vpage_d <= '0;
		end
		else
		begin
			zvpage_wr_r <= zvpage_wr;
			if (line_start || zvpage_wr_r)
				vpage_d <= vpage;	// mid-line page flip allowed
		end
	end

	assign vmode = vconf_d[1:0];
	assign rres = vconf_d[7:6];
	assign nogfx = vconf_d[5];
	assign render_mode = rmode_t'(vmode);	// same coding
	assign tv_hires = PIXRATE_HI[vmode];
	assign go_offs = G_OFFS[vmode];

	// raster window by resolution
	assign hpix_beg = HP_BEG[rres];
	assign hpix_end = HP_END[rres];
	assign vpix_beg = VP_BEG[rres];
	assign vpix_end = VP_END[rres];

	// fetch cadence per mode
	always_comb
	begin
		case (vmode)
			M_HC: ftch_rule = &fetch_cnt[1:0];	// every 4th c3
			M_XC: ftch_rule = fetch_cnt[0];	// every 2nd c3
			default: ftch_rule = &fetch_cnt;	// ZX and text, every 16th
		endcase
	end

	assign fetch_stb = c3 && fetch_win && (pix_start || ftch_rule);

	// ZX split-row layout, attrs at 0x1800
	assign addr_zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign addr_zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};

	// text sub-fetches by col[1:0]
	always_comb
	begin
		case (cnt_col[1:0])
			2'd0: addr_tx = {vpage_d[0], cnt_row[8:3], 1'b0, cnt_col[7:2]};	// char codes
			2'd1: addr_tx = {vpage_d[0], cnt_row[8:3], 1'b1, cnt_col[7:2]};	// attributes
			2'd2: addr_tx = {~vpage_d[0], 3'b000, txt_char[7:0], cnt_row[2:1]};	// glyph 0
			default: addr_tx = {~vpage_d[0], 3'b000, txt_char[15:8], cnt_row[2:1]};	// glyph 1
		endcase
	end

	always_comb
	begin
		case (vmode)
			M_ZX: video_addr = {vpage_d, 1'b0, cnt_col[0] ? addr_zx_atr : addr_zx_gfx};
			M_HC: video_addr = {vpage_d[7:3], cnt_row, cnt_col[6:0]};
			M_XC: video_addr = {vpage_d[7:4], cnt_row, cnt_col};
			default: video_addr = {vpage_d[7:1], addr_tx};
		endcase
	end

	// DRAM bandwidth
	always_comb
	begin
		case (vmode)
			M_ZX: video_bw = {BW8, BU1};	// 1 of 8
			M_HC: video_bw = {BW4, BU1};	// 1 of 4
			M_XC: video_bw = {BW2, BU1};	// 1 of 2
			default: video_bw = {BW8, BU4};	// 4 of 8 for text
		endcase
	end

	// word lanes and byte select
	always_comb
	begin
		fetch_bsl = 2'b10;
		case (vmode)
			M_ZX: fetch_sel = 4'b1100;
			M_HC, M_XC: fetch_sel = 4'b1111;	// full word
			default:
			begin
				case (cnt_col[1:0])
					2'd0: fetch_sel = 4'b0011;	// char
					2'd1: fetch_sel = 4'b1100;	// attr
					2'd2: fetch_sel = 4'b0001;	// gfx0
					default: fetch_sel = 4'b0010;	// gfx1
				endcase
				if (cnt_col[1])
					fetch_bsl = {2{cnt_row[0]}};	// glyph byte by odd row
			end
		endcase
	end

	// 256c scrolls in bytes, others in half-pixels
	assign x_offs_mode = {(vmode == M_XC) ? {gx_offs_d[8:1], 1'b0} : {1'b0, gx_offs_d[8:1]},
		gx_offs_d[0]};

	// strobe on an odd phase and never on the config latch clock
	a_fetch_phase: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_stb |-> f1 && !line_start);

endmodule

// ==== video_fetch.sv ====
// fetch issuer that registers each fetch descriptor and pulses a one-cycle DRAM request
`timescale 1ns/1ps

module video_fetch (
	input logic clk,
	input logic arst_n,
	input logic fetch_stb,
	input video_pkg::vaddr_t video_addr,
	input video_pkg::bw_t video_bw,
	input logic [3:0] fetch_sel,
	input logic [1:0] fetch_bsl,
	output logic dram_req,
	output video_pkg::vaddr_t dram_addr,
	output video_pkg::bw_t dram_bw,
	output logic [3:0] dram_sel,
	output logic [1:0] dram_bsl
);

	// request pulse, DRAM always takes it
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			dram_req <= 1'b0;
		else
			dram_req <= fetch_stb;
	end

	// descriptor held until next strobe
	always_ff @(posedge clk)
	begin
		if (fetch_stb)
		begin
			dram_addr <= video_addr;
			dram_bw <= video_bw;
			dram_sel <= fetch_sel;
			dram_bsl <= fetch_bsl;
		end
	end

	// strobes are c3-spaced so requests never merge
	a_req_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		dram_req |=> !dram_req);

endmodule

// ==== video_top.sv ====
// video top level joining raster timing, mode decoder and DRAM fetch issuer
`timescale 1ns/1ps

module video_top #(
	parameter int H_TOTAL = 448,
	parameter int V_TOTAL = 320
) (
	input logic clk,
	input logic arst_n,
	input logic [7:0] vconf,
	input logic [7:0] vpage,
	input logic zvpage_wr,
	input logic [8:0] gx_offs,
	input logic [15:0] txt_char,
	output logic dram_req,
	output video_pkg::vaddr_t dram_addr,
	output video_pkg::bw_t dram_bw,
	output logic [3:0] dram_sel,
	output logic [1:0] dram_bsl,
	output logic line_start,
	output logic [7:0] cnt_col,
	output video_pkg::raster_t cnt_row,
	output video_pkg::rmode_t render_mode,
	output logic tv_hires,
	output logic vga_hires,
	output logic nogfx,
	output logic [9:0] x_offs_mode
);

	import video_pkg::*;

	logic c3;
	logic f1;
	logic pix_start;
	logic fetch_win;
	logic [3:0] fetch_cnt;
	raster_t hpix_beg;	// window bounds back to timing
	raster_t hpix_end;
	raster_t vpix_beg;
	raster_t vpix_end;
	logic [4:0] go_offs;
	logic fetch_stb;
	logic [3:0] fetch_sel;
	logic [1:0] fetch_bsl;
	vaddr_t video_addr;
	bw_t video_bw;

	video_timing #(
		.H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL)
	) u_timing (
		.clk, .arst_n, .hpix_beg, .hpix_end, .vpix_beg, .vpix_end, .go_offs, .fetch_stb,
		.c3, .f1, .line_start, .pix_start, .fetch_win, .fetch_cnt, .cnt_col, .cnt_row
	);

	video_mode u_mode (
		.clk, .arst_n, .c3, .f1, .line_start, .pix_start, .fetch_win, .fetch_cnt,
		.cnt_col, .cnt_row, .vconf, .vpage, .zvpage_wr, .gx_offs, .txt_char,
		.hpix_beg, .hpix_end, .vpix_beg, .vpix_end, .go_offs, .x_offs_mode,
		.render_mode, .tv_hires, .vga_hires, .nogfx, .fetch_stb, .fetch_sel,
		.fetch_bsl, .video_addr, .video_bw
	);

	video_fetch u_fetch (
		.clk, .arst_n, .fetch_stb, .video_addr, .video_bw, .fetch_sel, .fetch_bsl,
		.dram_req, .dram_addr, .dram_bw, .dram_sel, .dram_bsl
	);

endmodule

// ==== tb_video.sv ====
// testbench for the video subsystem, checks the DRAM fetch stream and per-line config latching
`timescale 1ns/1ps

module tb_video;

	import video_pkg::*;

	localparam int H_TOTAL = 448;
	localparam int V_TOTAL = 320;
	localparam int LINE_CLKS = H_TOTAL * 4;	// one raster step per four clocks

	logic clk = 1'b0;
	logic arst_n;
	logic [7:0] vconf;
	logic [7:0] vpage;
	logic zvpage_wr;
	logic [8:0] gx_offs;
	logic [15:0] txt_char;
	logic dram_req;
	vaddr_t dram_addr;
	bw_t dram_bw;
	logic [3:0] dram_sel;
	logic [1:0] dram_bsl;
	logic line_start;
	logic [7:0] cnt_col;
	raster_t cnt_row;
	rmode_t render_mode;
	logic tv_hires;
	logic vga_hires;
	logic nogfx;
	logic [9:0] x_offs_mode;

	vmode_t exp_mode;	// config the DUT should be running
	rres_t exp_res;
	logic [7:0] exp_vpage;
	logic chk_en = 1'b0;
	int errors = 0;
	int tests = 0;
	int failed = 0;
	int err_mark = 0;
	int req_mark = 0;
	int req_total = 0;	// monitor counters
	int line_reqs = 0;
	int line_cnt = 0;
	int rows_seen = 0;
	int last_row = -1;
	longint cyc = 0;
	longint last_req_cyc = 0;

	video_top #(
		.H_TOTAL(H_TOTAL),
		.V_TOTAL(V_TOTAL)
	) u_video_top (
		.clk, .arst_n, .vconf, .vpage, .zvpage_wr, .gx_offs, .txt_char,
		.dram_req, .dram_addr, .dram_bw, .dram_sel, .dram_bsl, .line_start,
		.cnt_col, .cnt_row, .render_mode, .tv_hires, .vga_hires, .nogfx, .x_offs_mode
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// word address expected for one fetch
	function automatic vaddr_t exp_addr(input vmode_t mode, input logic [7:0] page,
		input logic [7:0] col, input raster_t row, input logic [15:0] tchar);
		int unsigned a;
		case (mode)
			M_ZX:
			begin
				if (col[0])
					a = 32'h0c00 + row[7:3] * 16 + col[4:1];	// attrs at byte 0x1800
				else
					a = row[7:6] * 1024 + row[2:0] * 128 + row[5:3] * 16 + col[4:1];
				a = a + page * 8192;
			end
			M_HC: a = page[7:3] * 65536 + row * 128 + col[6:0];
			M_XC: a = page[7:4] * 131072 + row * 256 + col;
			default:
			begin
				if (col[1])	// glyph lines in the other half
					a = (1 - page[0]) * 8192 + row[2:1]
						+ (col[0] ? tchar[15:8] : tchar[7:0]) * 4;
				else
					a = page[0] * 8192 + row[8:3] * 128 + col[0] * 64 + col[7:2];
				a = a + page[7:1] * 16384;
			end
		endcase
		return vaddr_t'(a);
	endfunction

	function automatic bw_t bw_for_mode(input vmode_t mode);
		case (mode)
			M_ZX: return 5'b11_001;	// 1 of 8
			M_HC: return 5'b01_001;
			M_XC: return 5'b00_001;
			default: return 5'b11_100;	// text, 4 of 8
		endcase
	endfunction

	function automatic logic [3:0] sel_for_fetch(input vmode_t mode, input logic [1:0] sub);
		if (mode == M_HC || mode == M_XC)
			return 4'b1111;
		if (mode == M_ZX)
			return 4'b1100;
		case (sub)	// char, attr, glyph0, glyph1
			2'd0: return 4'b0011;
			2'd1: return 4'b1100;
			2'd2: return 4'b0001;
			default: return 4'b0010;
		endcase
	endfunction

	// scroll offset, byte steps in 256c and half-pixel steps otherwise
	function automatic logic [9:0] xoffs_for_mode(input vmode_t mode, input logic [8:0] offs);
		if (mode == M_XC)
			return 10'(offs[8:1] * 4 + offs[0]);
		return 10'(offs);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("** Error: %s = %h, expected %h at %0t", name, got, want, $time);
		errors = errors + 1;
	endtask

	// comparison process, mid-cycle so outputs are settled
	always @(negedge clk)
	begin : monitor
		logic [7:0] col;
		logic [1:0] bsl;
		vaddr_t want;
		int gap;
		if (line_start)
		begin
			line_cnt = line_cnt + 1;
			line_reqs = 0;
		end
		if (dram_req)
		begin
			col = cnt_col - 8'd1;	// column stepped on the strobe edge
			if (exp_mode == M_TX && col[1])
				bsl = cnt_row[0] ? 2'b11 : 2'b00;	// glyph byte follows row parity
			else
				bsl = 2'b10;
			want = exp_addr(exp_mode, exp_vpage, col, cnt_row, txt_char);
			gap = (exp_mode == M_HC) ? 16 : (exp_mode == M_XC) ? 8 : 64;
			if (chk_en)
			begin
				if (dram_addr !== want)
					report_mismatch("dram_addr", dram_addr, want);
				if (dram_bw !== bw_for_mode(exp_mode))
					report_mismatch("dram_bw", dram_bw, bw_for_mode(exp_mode));
				if (dram_sel !== sel_for_fetch(exp_mode, col[1:0]))
					report_mismatch("dram_sel", dram_sel, sel_for_fetch(exp_mode, col[1:0]));
				if (dram_bsl !== bsl)
					report_mismatch("dram_bsl", dram_bsl, bsl);
				if (cnt_row >= VP_END[exp_res] - VP_BEG[exp_res])
					report_mismatch("cnt_row", cnt_row, VP_END[exp_res] - VP_BEG[exp_res]);
				if (line_reqs >= 2 && cyc - last_req_cyc != gap)	// skip first interval
					report_mismatch("dram_req spacing", 32'(cyc - last_req_cyc), gap);
				if (int'(cnt_row) != last_row)
				begin
					rows_seen = rows_seen + 1;
					last_row = cnt_row;
				end
			end
			req_total = req_total + 1;
			line_reqs = line_reqs + 1;
			last_req_cyc = cyc;
		end
	end

	// returns on the negedge inside the line_start cycle
	task automatic find_line();
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n = n + 1;
		end
		while (!line_start && n < LINE_CLKS + 8);
		if (!line_start)
		begin
			$display("timeout: no line_start within %0d clocks", n);
			$display("Simulation FAILED");
			$finish;
		end
	endtask

	task automatic enter_line();
		find_line();
		@(posedge clk);	// config latched here
		#1;
	endtask

	task automatic await_req();
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n = n + 1;
		end
		while (!dram_req && n < LINE_CLKS * V_TOTAL);
		if (!dram_req)
		begin
			$display("timeout: no dram_req within %0d clocks", n);
			$display("Simulation FAILED");
			$finish;
		end
	endtask

	task automatic run_lines(input int count);
		repeat (count)
			enter_line();
	endtask

	// new config with random page and text data, active from the next line
	task automatic configure(input vmode_t mode, input rres_t res, input logic gfx_off);
		chk_en = 1'b0;
		vconf = {res, gfx_off, 3'b000, mode};
		vpage = 8'($urandom);
		gx_offs = 9'($urandom);
		txt_char = 16'($urandom);
		exp_mode = mode;
		exp_res = res;
		exp_vpage = vpage;
		enter_line();
		if (x_offs_mode !== xoffs_for_mode(mode, gx_offs))
			report_mismatch("x_offs_mode", x_offs_mode, xoffs_for_mode(mode, gx_offs));
		rows_seen = 0;
		last_row = -1;
		chk_en = 1'b1;
	endtask

	task automatic end_test(input string name, input logic need_reqs);
		int n;
		if (need_reqs && req_total == req_mark)
		begin
			$display("no DRAM requests seen during %s", name);
			errors = errors + 1;
		end
		n = errors - err_mark;
		tests = tests + 1;
		if (n != 0)
			failed = failed + 1;
		$display("test %0d %s: %s, %0d errors", tests, name, n == 0 ? "ok" : "failed", n);
		err_mark = errors;
		req_mark = req_total;
	endtask

	initial
	begin
		int n;
		int mark;
		logic [7:0] page_new;
		void'($urandom(93));
		arst_n = 1'b0;
		vconf = '0;
		vpage = '0;
		zvpage_wr = 1'b0;
		gx_offs = '0;
		txt_char = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (dram_req !== 1'b0 || line_start !== 1'b0 || cnt_col !== 8'd0)
		begin
			$display("outputs not idle while in reset");
			errors = errors + 1;
		end
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		end_test("reset", 1'b0);

		configure(M_ZX, RES_256X192, 1'b0);	// one full frame
		run_lines(V_TOTAL);
		if (rows_seen != VP_END[RES_256X192] - VP_BEG[RES_256X192])
			report_mismatch("zx rows", rows_seen, VP_END[0] - VP_BEG[0]);
		end_test("zx frame", 1'b1);

		configure(M_HC, RES_320X200, 1'b0);
		await_req();
		run_lines(4);
		configure(M_XC, RES_320X240, 1'b0);
		await_req();
		run_lines(4);
		end_test("16c and 256c", 1'b1);

		configure(M_TX, RES_360X288, 1'b0);
		if (tv_hires !== 1'b1)
			report_mismatch("tv_hires", tv_hires, 1);
		for (int i = 0; i < 4; i++)
		begin
			await_req();	// first four of a line
			if (dram_sel !== 4'(16'h21c3 >> (4 * i)))
				report_mismatch("dram_sel", dram_sel, 4'(16'h21c3 >> (4 * i)));
		end
		run_lines(4);
		end_test("text", 1'b1);

		configure(M_HC, RES_256X192, 1'b0);
		chk_en = 1'b0;
		repeat (300) @(posedge clk);
		#1;
		vconf = {RES_256X192, 1'b1, 3'b000, M_TX};	// mid-line switch
		find_line();
		if (render_mode !== M_HC)
			report_mismatch("render_mode", render_mode, M_HC);
		if (nogfx !== 1'b0)
			report_mismatch("nogfx", nogfx, 0);
		if (vga_hires !== 1'b1)	// still from the text frame
			report_mismatch("vga_hires", vga_hires, 1);
		@(posedge clk);
		#1;
		if (render_mode !== M_TX)
			report_mismatch("render_mode", render_mode, M_TX);
		if (nogfx !== 1'b1)
			report_mismatch("nogfx", nogfx, 1);
		if (tv_hires !== 1'b1 || vga_hires !== 1'b0)
			report_mismatch("{tv_hires, vga_hires}", {tv_hires, vga_hires}, 2'b10);
		enter_line();
		if (vga_hires !== 1'b1)
			report_mismatch("vga_hires", vga_hires, 1);
		end_test("config latch", 1'b0);

		configure(M_XC, RES_320X240, 1'b0);
		n = 0;
		do
		begin
			await_req();
			@(posedge clk);
			n = n + 1;
		end
		while (line_reqs < 3 && n < 8);
		#1;
		page_new = vpage ^ 8'hf0;	// flips the 256c page bits
		vpage = page_new;
		zvpage_wr = 1'b1;
		exp_vpage = page_new;
		mark = line_cnt;
		@(posedge clk);
		#1;
		zvpage_wr = 1'b0;
		await_req();
		@(posedge clk);
		#1;
		if (line_cnt != mark)
		begin
			$display("page write was not seen before the line ended");
			errors = errors + 1;
		end
		if (dram_addr[20:17] !== page_new[7:4])
			report_mismatch("dram_addr[20:17]", dram_addr[20:17], page_new[7:4]);
		end_test("vpage write", 1'b1);

		for (int r = 0; r < 4; r++)
		begin
			configure(M_XC, rres_t'(r), 1'b0);
			run_lines(V_TOTAL);
			if (rows_seen != VP_END[r] - VP_BEG[r])
				report_mismatch("rows per frame", rows_seen, VP_END[r] - VP_BEG[r]);
		end
		chk_en = 1'b0;
		end_test("window bounds", 1'b1);

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
video_pkg.sv
video_timing.sv
video_mode.sv
video_fetch.sv
video_top.sv
tb_video.sv

// ==== Bender.yml ====
package:
  name: video_subsystem

sources:
  - video_pkg.sv
  - video_timing.sv
  - video_mode.sv
  - video_fetch.sv
  - video_top.sv
  - target: test
    files:
      - tb_video.sv
